// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dispatch_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/decoded_if.sv ====
`timescale 1ns/1ns

interface decoded_if
    import dispatch_pkg::*;
();
    op_e             op;
    kind_e           kind;
    logic [4:0]      rd;
    logic            uses_rs1;
    logic            uses_rs2;
    logic [XLEN-1:0] imm2;       // shamt or I-imm
    logic [XLEN-1:0] store_imm;
    logic            to_rs;
    logic            to_lsb;
    logic            rob_ready;
    logic [XLEN-1:0] rob_value;
    logic [XLEN-1:0] rob_target;
    logic            taken;

    modport decoder (output op, kind, rd, uses_rs1, uses_rs2, imm2, store_imm, to_rs,
                     to_lsb, rob_ready, rob_value, rob_target, taken);
    modport issue (input op, kind, rd, uses_rs1, uses_rs2, imm2, store_imm, to_rs,
                   to_lsb, rob_ready, rob_value, rob_target, taken);
endinterface

// ==== hw/dispatch_issue.sv ====
`timescale 1ns/1ns

module dispatch_issue
    import dispatch_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  logic             clk_in,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             accept,
    input  logic [XLEN-1:0]  fetch_pc,
    decoded_if.issue         dec,
    input  logic [XLEN-1:0]  rf_val1,
    input  logic [XLEN-1:0]  rf_val2,
    input  logic             rf_busy1,
    input  logic             rf_busy2,
    input  logic [TAG_W-1:0] rf_tag1,
    input  logic [TAG_W-1:0] rf_tag2,
    input  logic             rob_ready1,
    input  logic             rob_ready2,
    input  logic [XLEN-1:0]  rob_value1,
    input  logic [XLEN-1:0]  rob_value2,
    input  logic [TAG_W-1:0] rob_free_tag,
    output logic             rob_valid,
    output logic             rob_ready,
    output op_e              rob_op,
    output kind_e            rob_kind,
    output logic [XLEN-1:0]  rob_value,
    output logic [4:0]       rob_rd,
    output logic [XLEN-1:0]  rob_pc,
    output logic [XLEN-1:0]  rob_target,
    output logic             rob_taken,
    output logic             rs_valid,
    output logic             lsb_valid,
    output op_e              issue_op,
    output logic [TAG_W-1:0] issue_tag,
    output logic [XLEN-1:0]  issue_val1,
    output logic [XLEN-1:0]  issue_val2,
    output logic             issue_busy1,
    output logic             issue_busy2,
    output logic [TAG_W-1:0] issue_dep1,
    output logic [TAG_W-1:0] issue_dep2,
    output logic [XLEN-1:0]  issue_imm
);
    logic [XLEN-1:0] val1;
    logic [XLEN-1:0] val2;
    logic            busy1;
    logic            busy2;

    // rf value first, then a rob result that is already done
    function automatic logic [XLEN-1:0] operand(input logic used, input logic rf_busy,
                                                input logic rob_rdy,
                                                input logic [XLEN-1:0] rf_v,
                                                input logic [XLEN-1:0] rob_v);
        if (!used)
            return '0;
        if (!rf_busy)
            return rf_v;
        return rob_rdy ? rob_v : '0;
    endfunction

    assign val1  = operand(dec.uses_rs1, rf_busy1, rob_ready1, rf_val1, rob_value1);
    assign val2  = operand(dec.uses_rs2, rf_busy2, rob_ready2, rf_val2, rob_value2);
    assign busy1 = dec.uses_rs1 && rf_busy1 && !rob_ready1;
    assign busy2 = dec.uses_rs2 && rf_busy2 && !rob_ready2;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rob_valid <= 1'b0;
            rs_valid  <= 1'b0;
            lsb_valid <= 1'b0;
        end else begin
            rob_valid <= accept && !flush;      // one cycle per instruction
            rs_valid  <= accept && !flush && dec.to_rs;
            lsb_valid <= accept && !flush && dec.to_lsb;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            rob_ready   <= dec.rob_ready;
            rob_op      <= dec.op;
            rob_kind    <= dec.kind;
            rob_value   <= dec.rob_value;
            rob_rd      <= dec.rd;
            rob_pc      <= fetch_pc;
            rob_target  <= dec.rob_target;
            rob_taken   <= dec.taken;
            issue_op    <= dec.op;
            issue_tag   <= rob_free_tag;
            issue_val1  <= val1;
            issue_val2  <= dec.uses_rs2 ? val2 : dec.imm2;
            issue_busy1 <= busy1;
            issue_busy2 <= busy2;
            issue_dep1  <= rf_tag1;
            issue_dep2  <= rf_tag2;
            issue_imm   <= dec.store_imm;
        end
    end

    // rs and lsb routes never overlap
    a_route: assert property (@(posedge clk_in) disable iff (!arst_n)
        !(rs_valid && lsb_valid));

endmodule

// ==== hw/dispatch_pkg.sv ====
package dispatch_pkg;

    localparam int XLEN = 32;

    typedef enum logic [5:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_HALT
    } op_e;

    // rob entry kind
    typedef enum logic [2:0] {
        KIND_OTHER,     // lui, auipc, jal, jalr
        KIND_BRANCH,
        KIND_LOAD,
        KIND_STORE,
        KIND_ALU,
        KIND_HALT
    } kind_e;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

// ==== hw/dispatch_stage.sv ====
`timescale 1ns/1ns

module dispatch_stage
    import dispatch_pkg::*;
#(
    parameter int TAG_W = 4
) (
    input  logic             clk_in,
    input  logic             arst_n,
    input  logic             flush,
    // fetch
    input  logic             fetch_valid,
    input  logic [XLEN-1:0]  fetch_instr,
    input  logic [XLEN-1:0]  fetch_pc,
    input  logic             fetch_taken,
    output logic             stall,
    output logic [XLEN-1:0]  next_pc,
    output logic             next_pc_valid,
    // register file
    output logic [4:0]       rf_rs1,
    output logic [4:0]       rf_rs2,
    input  logic [XLEN-1:0]  rf_val1,
    input  logic [XLEN-1:0]  rf_val2,
    input  logic             rf_busy1,
    input  logic             rf_busy2,
    input  logic [TAG_W-1:0] rf_tag1,
    input  logic [TAG_W-1:0] rf_tag2,
    // rob lookup for rf_tag1/2
    input  logic             rob_ready1,
    input  logic             rob_ready2,
    input  logic [XLEN-1:0]  rob_value1,
    input  logic [XLEN-1:0]  rob_value2,
    // rob allocation
    input  logic             rob_full,
    input  logic [TAG_W-1:0] rob_free_tag,
    output logic             rob_valid,
    output logic             rob_ready,
    output op_e              rob_op,
    output kind_e            rob_kind,
    output logic [XLEN-1:0]  rob_value,
    output logic [4:0]       rob_rd,
    output logic [XLEN-1:0]  rob_pc,
    output logic [XLEN-1:0]  rob_target,
    output logic             rob_taken,
    // reservation station and lsb
    input  logic             rs_full,
    input  logic             lsb_full,
    output logic             rs_valid,
    output logic             lsb_valid,
    output op_e              issue_op,
    output logic [TAG_W-1:0] issue_tag,
    output logic [XLEN-1:0]  issue_val1,
    output logic [XLEN-1:0]  issue_val2,
    output logic             issue_busy1,
    output logic             issue_busy2,
    output logic [TAG_W-1:0] issue_dep1,
    output logic [TAG_W-1:0] issue_dep2,
    output logic [XLEN-1:0]  issue_imm
);
    logic accept;

    decoded_if dec_bus ();

    fetch_gate u_gate (
        .clk_in, .arst_n, .flush, .fetch_valid, .fetch_pc,
        .rob_full, .rs_full, .lsb_full, .stall, .accept
    );

    assign next_pc_valid = accept;

    rv32_decoder u_dec (
        .fetch_instr, .fetch_pc, .fetch_taken, .rf_rs1, .rf_rs2, .next_pc,
        .dec (dec_bus.decoder)
    );

    dispatch_issue #(.TAG_W(TAG_W)) u_issue (
        .clk_in, .arst_n, .flush, .accept, .fetch_pc,
        .dec (dec_bus.issue),
        .rf_val1, .rf_val2, .rf_busy1, .rf_busy2, .rf_tag1, .rf_tag2,
        .rob_ready1, .rob_ready2, .rob_value1, .rob_value2, .rob_free_tag,
        .rob_valid, .rob_ready, .rob_op, .rob_kind, .rob_value, .rob_rd, .rob_pc,
        .rob_target, .rob_taken, .rs_valid, .lsb_valid,
        .issue_op, .issue_tag, .issue_val1, .issue_val2, .issue_busy1, .issue_busy2,
        .issue_dep1, .issue_dep2, .issue_imm
    );

endmodule

// ==== hw/fetch_gate.sv ====
`timescale 1ns/1ns

module fetch_gate
    import dispatch_pkg::*;
(
    input  logic            clk_in,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            fetch_valid,
    input  logic [XLEN-1:0] fetch_pc,
    input  logic            rob_full,
    input  logic            rs_full,
    input  logic            lsb_full,
    output logic            stall,
    output logic            accept
);
    logic [XLEN-1:0] last_pc;

    assign stall  = rob_full || rs_full || lsb_full;
    assign accept = fetch_valid && !stall && (fetch_pc != last_pc);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            last_pc <= '1;
        end else if (flush) begin
            last_pc <= '1;          // re-arm duplicate filter
        end else if (accept) begin
            last_pc <= fetch_pc;
        end
    end

    // fetch holds a stalled instruction
    a_fetch_hold: assert property (@(posedge clk_in) disable iff (!arst_n)
        (fetch_valid && stall) |=> (fetch_valid && fetch_pc == $past(fetch_pc)));

endmodule

// ==== hw/rv32_decoder.sv ====
`timescale 1ns/1ns

module rv32_decoder
    import dispatch_pkg::*;
(
    input  logic [XLEN-1:0] fetch_instr,
    input  logic [XLEN-1:0] fetch_pc,
    input  logic            fetch_taken,
    output logic [4:0]      rf_rs1,
    output logic [4:0]      rf_rs2,
    output logic [XLEN-1:0] next_pc,
    decoded_if.decoder      dec
);
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;       // funct7[5]
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] shamt;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_branch;
    op_e             op;
    kind_e           kind;

    assign opcode = fetch_instr[6:0];
    assign funct3 = fetch_instr[14:12];
    assign alt    = fetch_instr[30];
    assign rf_rs1 = fetch_instr[19:15];
    assign rf_rs2 = fetch_instr[24:20];

    assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
    assign imm_s = {{20{fetch_instr[31]}}, fetch_instr[31:25], fetch_instr[11:7]};
    assign imm_b = {{20{fetch_instr[31]}}, fetch_instr[7], fetch_instr[30:25],
                    fetch_instr[11:8], 1'b0};
    assign imm_u = {fetch_instr[31:12], 12'b0};
    assign imm_j = {{12{fetch_instr[31]}}, fetch_instr[19:12], fetch_instr[20],
                    fetch_instr[30:21], 1'b0};
    assign shamt = {27'b0, fetch_instr[24:20]};

    assign pc_plus4  = fetch_pc + 32'd4;
    assign pc_branch = fetch_pc + imm_b;

    always_comb begin
        op = OP_HALT;               // unknown encodings halt
        case (opcode)
            OPC_LUI:    op = OP_LUI;
            OPC_AUIPC:  op = OP_AUIPC;
            OPC_JAL:    op = OP_JAL;
            OPC_JALR:   op = OP_JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000: op = OP_BEQ;
                    3'b001: op = OP_BNE;
                    3'b100: op = OP_BLT;
                    3'b101: op = OP_BGE;
                    3'b110: op = OP_BLTU;
                    3'b111: op = OP_BGEU;
                    default: op = OP_HALT;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000: op = OP_LB;
                    3'b001: op = OP_LH;
                    3'b010: op = OP_LW;
                    3'b100: op = OP_LBU;
                    3'b101: op = OP_LHU;
                    default: op = OP_HALT;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000: op = OP_SB;
                    3'b001: op = OP_SH;
                    3'b010: op = OP_SW;
                    default: op = OP_HALT;
                endcase
            end
            OPC_OPIMM: begin
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b001: op = OP_SLLI;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b101: op = alt ? OP_SRAI : OP_SRLI;
                    3'b110: op = OP_ORI;
                    default: op = OP_ANDI;
                endcase
            end
            OPC_OP: begin
                case (funct3)
                    3'b000: op = alt ? OP_SUB : OP_ADD;
                    3'b001: op = OP_SLL;
                    3'b010: op = OP_SLT;
                    3'b011: op = OP_SLTU;
                    3'b100: op = OP_XOR;
                    3'b101: op = alt ? OP_SRA : OP_SRL;
                    3'b110: op = OP_OR;
                    default: op = OP_AND;
                endcase
            end
            default: op = OP_HALT;
        endcase
    end

    // kind follows the enum ordering
    always_comb begin
        if (op <= OP_JALR)      kind = KIND_OTHER;
        else if (op <= OP_BGEU) kind = KIND_BRANCH;
        else if (op <= OP_LHU)  kind = KIND_LOAD;
        else if (op <= OP_SW)   kind = KIND_STORE;
        else if (op <= OP_AND)  kind = KIND_ALU;
        else                    kind = KIND_HALT;
    end

    always_comb begin
        case (op)
            OP_LUI:         dec.rob_value = imm_u;
            OP_AUIPC:       dec.rob_value = fetch_pc + imm_u;
            OP_JAL, OP_JALR: dec.rob_value = pc_plus4;   // link address
            default:        dec.rob_value = '0;
        endcase
    end

    assign dec.op        = op;
    assign dec.kind      = kind;
    assign dec.rd        = (kind inside {KIND_BRANCH, KIND_STORE}) ? 5'd0 : fetch_instr[11:7];
    assign dec.uses_rs1  = !(op inside {OP_LUI, OP_AUIPC, OP_JAL});
    assign dec.uses_rs2  = (kind inside {KIND_BRANCH, KIND_STORE}) ||
                           (kind == KIND_ALU && op >= OP_ADD);
    assign dec.imm2      = (op inside {OP_SLLI, OP_SRLI, OP_SRAI}) ? shamt : imm_i;
    assign dec.store_imm = (kind == KIND_STORE) ? imm_s : '0;
    assign dec.to_lsb    = kind inside {KIND_LOAD, KIND_STORE};
    assign dec.to_rs     = (op == OP_JALR) || (kind inside {KIND_BRANCH, KIND_ALU});
    assign dec.rob_ready = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_HALT};
    assign dec.rob_target = (kind == KIND_BRANCH) ? pc_branch : '0;
    assign dec.taken     = (op inside {OP_JAL, OP_JALR}) || (kind == KIND_BRANCH && fetch_taken);

    // jal always taken, branches as fetch predicts
    assign next_pc = (op == OP_JAL) ? fetch_pc + imm_j :
                     (kind == KIND_BRANCH && fetch_taken) ? pc_branch : pc_plus4;

endmodule

// ==== include/dispatch_ref_model.svh ====
`ifndef DISPATCH_REF_MODEL_SVH
`define DISPATCH_REF_MODEL_SVH

// expected record without the pass-through tags
typedef struct packed {
    logic        rs_valid;
    logic        lsb_valid;
    op_e         op;
    kind_e       kind;
    logic        ready;
    logic [31:0] value;
    logic [4:0]  rd;
    logic [31:0] target;
    logic        taken;
    logic [31:0] val1;
    logic [31:0] val2;
    logic        busy1;
    logic        busy2;
    logic [31:0] imm;
    logic [31:0] next_pc;
} ref_rec_t;

function automatic ref_rec_t ref_dispatch(input logic [31:0] instr, input logic [31:0] pc,
                                          input logic pred,
                                          input logic [31:0] rf_v1, input logic [31:0] rf_v2,
                                          input logic rf_b1, input logic rf_b2,
                                          input logic rob_r1, input logic rob_r2,
                                          input logic [31:0] rob_v1,
                                          input logic [31:0] rob_v2);
    ref_rec_t    r;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic        u1;
    logic        u2;
    r = '0;
    f3 = instr[14:12];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    r.op = OP_HALT;
    r.kind = KIND_HALT;
    case (instr[6:0])
        OPC_LUI:   r.op = OP_LUI;
        OPC_AUIPC: r.op = OP_AUIPC;
        OPC_JAL:   r.op = OP_JAL;
        OPC_JALR:  r.op = OP_JALR;
        OPC_BRANCH: if (f3 != 3'd2 && f3 != 3'd3) r.op = op_e'(OP_BEQ + (f3[2] ? f3 - 2 : f3));
        OPC_LOAD:   if (f3 inside {0, 1, 2, 4, 5}) r.op = op_e'(OP_LB + (f3[2] ? f3 - 1 : f3));
        OPC_STORE:  if (f3 < 3) r.op = op_e'(OP_SB + f3);
        OPC_OPIMM: begin
            case (f3)
                3'd0: r.op = OP_ADDI;
                3'd1: r.op = OP_SLLI;
                3'd2: r.op = OP_SLTI;
                3'd3: r.op = OP_SLTIU;
                3'd4: r.op = OP_XORI;
                3'd5: r.op = instr[30] ? OP_SRAI : OP_SRLI;
                3'd6: r.op = OP_ORI;
                default: r.op = OP_ANDI;
            endcase
        end
        OPC_OP: begin
            case (f3)
                3'd0: r.op = instr[30] ? OP_SUB : OP_ADD;
                3'd1: r.op = OP_SLL;
                3'd2: r.op = OP_SLT;
                3'd3: r.op = OP_SLTU;
                3'd4: r.op = OP_XOR;
                3'd5: r.op = instr[30] ? OP_SRA : OP_SRL;
                3'd6: r.op = OP_OR;
                default: r.op = OP_AND;
            endcase
        end
        default: r.op = OP_HALT;
    endcase
    if (r.op != OP_HALT) begin
        case (instr[6:0])
            OPC_BRANCH: r.kind = KIND_BRANCH;
            OPC_LOAD:   r.kind = KIND_LOAD;
            OPC_STORE:  r.kind = KIND_STORE;
            OPC_OPIMM, OPC_OP: r.kind = KIND_ALU;
            default:    r.kind = KIND_OTHER;
        endcase
    end
    u1 = !(r.op inside {OP_LUI, OP_AUIPC, OP_JAL});
    u2 = r.kind inside {KIND_BRANCH, KIND_STORE} || (r.kind == KIND_ALU && instr[5]);
    r.rs_valid = r.op == OP_JALR || r.kind inside {KIND_BRANCH, KIND_ALU};
    r.lsb_valid = r.kind inside {KIND_LOAD, KIND_STORE};
    r.ready = r.op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_HALT};
    if (r.op == OP_LUI)
        r.value = {instr[31:12], 12'b0};
    else if (r.op == OP_AUIPC)
        r.value = pc + {instr[31:12], 12'b0};
    else if (r.op inside {OP_JAL, OP_JALR})
        r.value = pc + 4;
    r.rd = r.kind inside {KIND_BRANCH, KIND_STORE} ? 5'd0 : instr[11:7];
    r.target = r.kind == KIND_BRANCH ? pc + imm_b : 32'd0;
    r.taken = r.op inside {OP_JAL, OP_JALR} || (r.kind == KIND_BRANCH && pred);
    r.val1 = !u1 ? 32'd0 : !rf_b1 ? rf_v1 : rob_r1 ? rob_v1 : 32'd0;
    r.busy1 = u1 && rf_b1 && !rob_r1;
    r.val2 = !u2 ? imm_i : !rf_b2 ? rf_v2 : rob_r2 ? rob_v2 : 32'd0;
    if (r.op inside {OP_SLLI, OP_SRLI, OP_SRAI})
        r.val2 = {27'b0, instr[24:20]};
    r.busy2 = u2 && rf_b2 && !rob_r2;
    if (r.kind == KIND_STORE)
        r.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    if (r.op == OP_JAL)
        r.next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    else
        r.next_pc = (r.kind == KIND_BRANCH && pred) ? pc + imm_b : pc + 4;
    return r;
endfunction

`endif

// ==== sim/dispatch_tb.sv ====
`timescale 1ns/1ns

module dispatch_tb
    import dispatch_pkg::*;
();
    localparam int TAG_W  = 4;
    localparam int PERIOD = 100;

    `include "dispatch_ref_model.svh"

    typedef struct packed {
        logic             acc;      // record expected one edge later
        logic             npv;
        logic             stall;
        logic [XLEN-1:0]  instr;
        logic [XLEN-1:0]  pc;
        logic [TAG_W-1:0] tag;
        logic [TAG_W-1:0] dep1;
        logic [TAG_W-1:0] dep2;
        ref_rec_t         rec;
    } exp_t;

    logic             clk_in, arst_n, flush;
    logic             fetch_valid, fetch_taken, stall, next_pc_valid;
    logic [XLEN-1:0]  fetch_instr, fetch_pc, next_pc;
    logic [4:0]       rf_rs1, rf_rs2, rob_rd;
    logic [XLEN-1:0]  rf_val1, rf_val2, rob_value1, rob_value2;
    logic             rf_busy1, rf_busy2, rob_ready1, rob_ready2;
    logic [TAG_W-1:0] rf_tag1, rf_tag2, rob_free_tag, issue_tag, issue_dep1, issue_dep2;
    logic             rob_full, rs_full, lsb_full;
    logic             rob_valid, rob_ready, rob_taken, rs_valid, lsb_valid;
    logic             issue_busy1, issue_busy2;
    logic [XLEN-1:0]  rob_value, rob_pc, rob_target, issue_val1, issue_val2, issue_imm;
    op_e              rob_op, issue_op;
    kind_e            rob_kind;

    exp_t             exp_q[$];
    logic [XLEN-1:0]  cur_pc;
    logic [XLEN-1:0]  last_pc_model;   // mirror of the duplicate filter
    logic             allow_idle;
    logic             held;
    int               checks;
    int               errors;

    dispatch_stage #(.TAG_W(TAG_W)) dut (.*);

    always #(PERIOD / 2) clk_in = ~clk_in;

    // legal encodings of every class, plus one system opcode for halt
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [2:0]  f3;
        r  = $urandom;
        f3 = r[14:12];
        case ($urandom_range(9, 0))
            0: r[6:0] = OPC_LUI;
            1: r[6:0] = OPC_AUIPC;
            2: r[6:0] = OPC_JAL;
            3: begin
                r[6:0]   = OPC_JALR;
                r[14:12] = 3'b000;
            end
            4: begin
                r[6:0] = OPC_BRANCH;
                if (f3[2:1] == 2'b01)
                    r[13] = 1'b0;       // 010/011 are reserved
            end
            5: begin
                r[6:0] = OPC_LOAD;
                if (f3 == 3'd3 || f3 >= 3'd6)
                    r[14:12] = 3'd2;
            end
            6: begin
                r[6:0]   = OPC_STORE;
                r[14:12] = 3'($urandom_range(2, 0));
            end
            7: begin
                r[6:0] = OPC_OPIMM;
                if (f3 == 3'd1 || f3 == 3'd5)
                    r[31:25] = (f3 == 3'd5 && r[30]) ? 7'h20 : 7'h00;
            end
            8: begin
                r[6:0]   = OPC_OP;
                r[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
            end
            default: r[6:0] = 7'b1110011;
        endcase
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic drive_step(input logic new_fetch, input logic [2:0] full, input logic fl);
        exp_t e;
        @(negedge clk_in);
        if (new_fetch) begin
            cur_pc      = cur_pc + 32'(4 * $urandom_range(64, 1));
            fetch_pc    = cur_pc;
            fetch_instr = random_instr();
            fetch_taken = 1'($urandom_range(1, 0));
            fetch_valid = !(allow_idle && $urandom_range(9, 0) == 0);
        end
        {rob_full, rs_full, lsb_full} = full;
        flush        = fl;
        rf_val1      = $urandom;
        rf_val2      = $urandom;
        rob_value1   = $urandom;
        rob_value2   = $urandom;
        rf_busy1     = 1'($urandom_range(1, 0));
        rf_busy2     = 1'($urandom_range(1, 0));
        rob_ready1   = 1'($urandom_range(1, 0));
        rob_ready2   = 1'($urandom_range(1, 0));
        rf_tag1      = TAG_W'($urandom);
        rf_tag2      = TAG_W'($urandom);
        rob_free_tag = TAG_W'($urandom);
        e.stall = (full != 3'b000);
        e.npv   = fetch_valid && !e.stall && (fetch_pc != last_pc_model);
        e.acc   = e.npv && !fl;                     // flush wins over accept
        e.instr = fetch_instr;
        e.pc    = fetch_pc;
        e.tag   = rob_free_tag;
        e.dep1  = rf_tag1;
        e.dep2  = rf_tag2;
        e.rec   = ref_dispatch(fetch_instr, fetch_pc, fetch_taken, rf_val1, rf_val2,
                               rf_busy1, rf_busy2, rob_ready1, rob_ready2,
                               rob_value1, rob_value2);
        if (fl)
            last_pc_model = '1;
        else if (e.acc)
            last_pc_model = fetch_pc;
        exp_q.push_back(e);
    endtask

    task automatic check_fetch_side(input exp_t e);
        check_field("stall", 32'(stall), 32'(e.stall));
        check_field("next_pc_valid", 32'(next_pc_valid), 32'(e.npv));
        check_field("rf_rs1", 32'(rf_rs1), 32'(e.instr[19:15]));
        check_field("rf_rs2", 32'(rf_rs2), 32'(e.instr[24:20]));
        if (e.npv)
            check_field("next_pc", next_pc, e.rec.next_pc);
    endtask

    task automatic compare_record(input exp_t e);
        check_field("rob_valid", 32'(rob_valid), 32'(e.acc));
        check_field("rs_valid", 32'(rs_valid), 32'(e.acc && e.rec.rs_valid));
        check_field("lsb_valid", 32'(lsb_valid), 32'(e.acc && e.rec.lsb_valid));
        if (e.acc) begin
            check_field("rob_ready", 32'(rob_ready), 32'(e.rec.ready));
            check_field("rob_op", 32'(rob_op), 32'(e.rec.op));
            check_field("rob_kind", 32'(rob_kind), 32'(e.rec.kind));
            check_field("rob_value", rob_value, e.rec.value);
            check_field("rob_rd", 32'(rob_rd), 32'(e.rec.rd));
            check_field("rob_pc", rob_pc, e.pc);
            check_field("rob_target", rob_target, e.rec.target);
            check_field("rob_taken", 32'(rob_taken), 32'(e.rec.taken));
            check_field("issue_op", 32'(issue_op), 32'(e.rec.op));
            check_field("issue_tag", 32'(issue_tag), 32'(e.tag));
            check_field("issue_val1", issue_val1, e.rec.val1);
            check_field("issue_val2", issue_val2, e.rec.val2);
            check_field("issue_busy1", 32'(issue_busy1), 32'(e.rec.busy1));
            check_field("issue_busy2", 32'(issue_busy2), 32'(e.rec.busy2));
            check_field("issue_dep1", 32'(issue_dep1), 32'(e.dep1));
            check_field("issue_dep2", 32'(issue_dep2), 32'(e.dep2));
            check_field("issue_imm", issue_imm, e.rec.imm);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    // comb outputs mid low phase, registered outputs mid high phase
    always begin
        @(negedge clk_in);
        #(PERIOD / 4);
        if (exp_q.size() > 0)
            check_fetch_side(exp_q[$]);
        @(posedge clk_in);
        #(PERIOD / 4);
        if (exp_q.size() > 0)
            compare_record(exp_q.pop_front());
    end

    initial begin
        int         i;
        int         wait_cnt;
        logic [2:0] full;
        void'($urandom(22));
        clk_in = 1'b0;
        arst_n = 1'b0;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_taken = 1'b0;
        fetch_instr = '0;
        fetch_pc = '0;
        {rf_val1, rf_val2, rob_value1, rob_value2} = '0;
        {rf_busy1, rf_busy2, rob_ready1, rob_ready2} = '0;
        {rf_tag1, rf_tag2, rob_free_tag} = '0;
        {rob_full, rs_full, lsb_full} = '0;
        cur_pc = 32'h0000_1000;
        last_pc_model = '1;
        allow_idle = 1'b1;
        held = 1'b0;
        checks = 0;
        errors = 0;
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
        for (i = 0; i < 400; i++) begin
            full = 3'b000;
            if ($urandom_range(7, 0) == 0)
                full = 3'(1 << $urandom_range(2, 0));
            drive_step(!held && $urandom_range(5, 0) != 0, full, $urandom_range(24, 0) == 0);
            held = (full != 3'b000);                // fetch holds while stalled
        end
        allow_idle = 1'b0;
        if (held)
            drive_step(1'b0, 3'b000, 1'b0);         // release the held fetch first
        drive_step(1'b1, 3'b100, 1'b0);             // each full input alone
        drive_step(1'b0, 3'b010, 1'b0);
        drive_step(1'b0, 3'b001, 1'b0);
        drive_step(1'b0, 3'b000, 1'b0);
        drive_step(1'b0, 3'b000, 1'b0);             // same pc, filtered
        drive_step(1'b1, 3'b000, 1'b0);
        drive_step(1'b0, 3'b000, 1'b1);             // flush re-arms the filter
        drive_step(1'b0, 3'b000, 1'b0);
        drive_step(1'b0, 3'b000, 1'b0);
        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < 20) begin
            @(posedge clk_in);
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: expected dispatch records were never checked");
            errors++;
        end
        finish_run();
    end

endmodule

// ==== tb.f ====
+incdir+include
hw/dispatch_pkg.sv
hw/decoded_if.sv
hw/fetch_gate.sv
hw/rv32_decoder.sv
hw/dispatch_issue.sv
hw/dispatch_stage.sv
sim/dispatch_tb.sv
